// ==== xt_pkg.sv ====
// ====================
// Shared widths, address map and bus cycle types for the chipset core.
// Files refer to these by scoped names.
// ====================
`default_nettype none

package xt_pkg;

    parameter int ADDR_W = 20;
    parameter int DATA_W = 8;
    parameter int DMA_CH = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Timer divisor register in I/O space
    parameter addr_t TIMER_PORT = 20'h00041;

    // One-hot command, active high
    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic io_read;
        logic io_write;
    } bus_cmd_t;

    typedef struct packed {
        addr_t    address;
        data_t    wdata;
        bus_cmd_t cmd;
    } bus_cycle_t;

    typedef enum logic [1:0] {
        SRC_EXT,
        SRC_RAM,
        SRC_CHIPSET
    } read_src_t;

endpackage

`default_nettype wire

// ==== refresh_request.sv ====
// ====================
// Memory refresh request for DMA channel 0.
// Set on each timer output rising edge, cleared by the acknowledge.
// ====================
`timescale 1ns/1ps
`default_nettype none

module refresh_request (
    input  logic clock,
    input  logic reset,
    input  logic timer_out,
    input  logic dma0_acknowledge_n,
    output logic refresh_drq
);

    logic prev_timer_out;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_timer_out <= 1'b0;
            refresh_drq    <= 1'b0;
        end else begin
            prev_timer_out <= timer_out;
            // Acknowledge wins over a new edge
            if (~dma0_acknowledge_n)
                refresh_drq <= 1'b0;
            else if (~prev_timer_out & timer_out)
                refresh_drq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dma_arbiter.sv ====
// ====================
// Fixed-priority DMA arbiter, channel 0 highest.
// A grant lasts DMA_CYCLES clocks and only starts while the CPU is idle.
// ====================
`timescale 1ns/1ps
`default_nettype none

module dma_arbiter #(
    parameter int DMA_CYCLES = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [xt_pkg::DMA_CH-1:0] dma_request,
    input  logic                      cpu_busy,
    output logic [xt_pkg::DMA_CH-1:0] dma_acknowledge_n,
    output logic                      address_enable
);

    localparam int CNT_W = $clog2(DMA_CYCLES + 1);

    logic [xt_pkg::DMA_CH-1:0] grant;
    logic [xt_pkg::DMA_CH-1:0] next_grant;
    logic [CNT_W-1:0]          grant_count;

    // Lowest-numbered request wins
    always_comb begin
        next_grant = '0;
        for (int ch = xt_pkg::DMA_CH - 1; ch >= 0; ch--) begin
            if (dma_request[ch])
                next_grant = xt_pkg::DMA_CH'(1) << ch;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            grant       <= '0;
            grant_count <= '0;
        end else if (grant == '0) begin
            if (~cpu_busy && (dma_request != '0)) begin
                grant       <= next_grant;
                grant_count <= CNT_W'(DMA_CYCLES - 1);
            end
        end else if (grant_count == '0) begin
            // Back to idle, leaves one free cycle before the next grant
            grant <= '0;
        end else begin
            grant_count <= grant_count - 1'b1;
        end
    end

    assign dma_acknowledge_n = ~grant;
    assign address_enable    = |grant;

endmodule

`default_nettype wire

// ==== ready_gen.sv ====
// ====================
// Wait-state counter for CPU bus cycles.
// Drives processor_ready and the one-cycle cycle_done strobe.
// ====================
`timescale 1ns/1ps
`default_nettype none

module ready_gen #(
    parameter int WAIT_STATES = 1
) (
    input  logic clock,
    input  logic reset,
    input  logic cpu_start,
    input  logic io_channel_ready,
    input  logic address_enable,
    output logic processor_ready,
    output logic cycle_done
);

    localparam int CNT_W = $clog2(WAIT_STATES + 2);

    logic             in_cycle;
    logic [CNT_W-1:0] wait_count;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            in_cycle   <= 1'b0;
            wait_count <= '0;
        end else if (cpu_start) begin
            in_cycle   <= 1'b1;
            wait_count <= CNT_W'(WAIT_STATES + 1);
        end else if (cycle_done) begin
            in_cycle <= 1'b0;
        end else if (wait_count != '0) begin
            wait_count <= wait_count - 1'b1;
        end
    end

    // Count expired, then hold for the I/O channel
    assign cycle_done      = in_cycle & (wait_count == '0) & io_channel_ready;
    assign processor_ready = ~(in_cycle | address_enable);

endmodule

`default_nettype wire

// ==== interval_timer.sv ====
// ====================
// Interval timer with a CPU-writable divisor at TIMER_PORT.
// timer_out toggles every divisor clocks, a zero divisor stops it.
// ====================
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
    input  logic               clock,
    input  logic               reset,
    input  xt_pkg::bus_cycle_t active_cycle,
    input  logic               access_strobe,
    output xt_pkg::data_t      timer_rdata,
    output logic               timer_out
);

    xt_pkg::data_t divisor;
    xt_pkg::data_t count;
    logic          divisor_write;

    assign divisor_write = access_strobe & active_cycle.cmd.io_write &
                           (active_cycle.address == xt_pkg::TIMER_PORT);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            divisor   <= '0;
            count     <= '0;
            timer_out <= 1'b0;
        end else if (divisor_write) begin
            divisor <= active_cycle.wdata;
            count   <= '0;
        end else if (divisor == '0) begin
            count <= '0;
        end else if (count == divisor - 1'b1) begin
            count     <= '0;
            timer_out <= ~timer_out;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign timer_rdata = divisor;

endmodule

`default_nettype wire

// ==== bus_decode.sv ====
// ====================
// CPU cycle latch and address decode.
// Picks read data from chipset register, local RAM or the external bus.
// ====================
`timescale 1ns/1ps
`default_nettype none

module bus_decode #(
    parameter int RAM_BYTES = 1024
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               cpu_start,
    input  xt_pkg::bus_cycle_t cpu_cycle,
    input  logic               cycle_done,
    input  xt_pkg::data_t      ram_rdata,
    input  xt_pkg::data_t      timer_rdata,
    input  xt_pkg::data_t      data_bus_ext,
    output xt_pkg::bus_cycle_t active_cycle,
    output logic               access_strobe,
    output logic               cpu_busy,
    output xt_pkg::data_t      read_data,
    output xt_pkg::data_t      data_bus
);

    logic              busy_q;
    xt_pkg::read_src_t read_src;

    always_ff @(posedge clock) begin
        if (cpu_start)
            active_cycle <= cpu_cycle;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            access_strobe <= 1'b0;
            busy_q        <= 1'b0;
        end else begin
            access_strobe <= cpu_start;
            if (cpu_start)
                busy_q <= 1'b1;
            else if (cycle_done)
                busy_q <= 1'b0;
        end
    end

    // Covers the start cycle too, so DMA cannot slip in
    assign cpu_busy = cpu_start | busy_q;

    always_comb begin
        if (active_cycle.cmd.io_read && (active_cycle.address == xt_pkg::TIMER_PORT))
            read_src = xt_pkg::SRC_CHIPSET;
        else if (active_cycle.cmd.mem_read && (active_cycle.address < xt_pkg::ADDR_W'(RAM_BYTES)))
            read_src = xt_pkg::SRC_RAM;
        else
            read_src = xt_pkg::SRC_EXT;
    end

    always_comb begin
        case (read_src)
            xt_pkg::SRC_CHIPSET: read_data = timer_rdata;
            xt_pkg::SRC_RAM:     read_data = ram_rdata;
            default:             read_data = data_bus_ext;
        endcase
    end

    assign data_bus = active_cycle.wdata;

endmodule

`default_nettype wire

// ==== ram_block.sv ====
// ====================
// Local byte RAM at the bottom of memory space.
// Write on access_strobe, registered read of the latched address.
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_block #(
    parameter int RAM_BYTES = 1024
) (
    input  logic               clock,
    input  xt_pkg::bus_cycle_t active_cycle,
    input  logic               access_strobe,
    output xt_pkg::data_t      ram_rdata
);

    localparam int IDX_W = $clog2(RAM_BYTES);

    xt_pkg::data_t    mem [RAM_BYTES];
    logic [IDX_W-1:0] index;
    logic             in_range;

    assign index    = active_cycle.address[IDX_W-1:0];
    assign in_range = active_cycle.address < xt_pkg::ADDR_W'(RAM_BYTES);

    always_ff @(posedge clock) begin
        if (access_strobe && active_cycle.cmd.mem_write && in_range)
            mem[index] <= active_cycle.wdata;
        ram_rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== xt_chipset.sv ====
// ====================
// XT-class chipset core top level.
// Sets wait states, DMA grant length and RAM size for the blocks below.
// ====================
`timescale 1ns/1ps
`default_nettype none

module xt_chipset #(
    parameter int WAIT_STATES = 1,
    parameter int DMA_CYCLES  = 4,
    parameter int RAM_BYTES   = 1024
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      cpu_start,
    input  xt_pkg::bus_cycle_t        cpu_cycle,
    input  xt_pkg::data_t             data_bus_ext,
    input  logic [xt_pkg::DMA_CH-1:1] dma_request,
    input  logic                      io_channel_ready,
    output logic                      processor_ready,
    output logic                      cycle_done,
    output xt_pkg::data_t             read_data,
    output xt_pkg::data_t             data_bus,
    output logic                      timer_out,
    output logic [xt_pkg::DMA_CH-1:0] dma_acknowledge_n,
    output logic                      address_enable
);

    xt_pkg::bus_cycle_t active_cycle;
    logic               access_strobe;
    logic               cpu_busy;
    logic               refresh_drq;
    xt_pkg::data_t      ram_rdata;
    xt_pkg::data_t      timer_rdata;

    bus_decode #(.RAM_BYTES(RAM_BYTES)) u_bus_decode (
        .clock         (clock),
        .reset         (reset),
        .cpu_start     (cpu_start),
        .cpu_cycle     (cpu_cycle),
        .cycle_done    (cycle_done),
        .ram_rdata     (ram_rdata),
        .timer_rdata   (timer_rdata),
        .data_bus_ext  (data_bus_ext),
        .active_cycle  (active_cycle),
        .access_strobe (access_strobe),
        .cpu_busy      (cpu_busy),
        .read_data     (read_data),
        .data_bus      (data_bus)
    );

    ready_gen #(.WAIT_STATES(WAIT_STATES)) u_ready_gen (
        .clock            (clock),
        .reset            (reset),
        .cpu_start        (cpu_start),
        .io_channel_ready (io_channel_ready),
        .address_enable   (address_enable),
        .processor_ready  (processor_ready),
        .cycle_done       (cycle_done)
    );

    ram_block #(.RAM_BYTES(RAM_BYTES)) u_ram_block (
        .clock         (clock),
        .active_cycle  (active_cycle),
        .access_strobe (access_strobe),
        .ram_rdata     (ram_rdata)
    );

    interval_timer u_interval_timer (
        .clock         (clock),
        .reset         (reset),
        .active_cycle  (active_cycle),
        .access_strobe (access_strobe),
        .timer_rdata   (timer_rdata),
        .timer_out     (timer_out)
    );

    refresh_request u_refresh_request (
        .clock              (clock),
        .reset              (reset),
        .timer_out          (timer_out),
        .dma0_acknowledge_n (dma_acknowledge_n[0]),
        .refresh_drq        (refresh_drq)
    );

    // Channel 0 is refresh
    dma_arbiter #(.DMA_CYCLES(DMA_CYCLES)) u_dma_arbiter (
        .clock             (clock),
        .reset             (reset),
        .dma_request       ({dma_request, refresh_drq}),
        .cpu_busy          (cpu_busy),
        .dma_acknowledge_n (dma_acknowledge_n),
        .address_enable    (address_enable)
    );

endmodule

`default_nettype wire

// ==== xt_chipset_props.sv ====
// ====================
// Bus ownership and handshake assertions.
// Bound into the chipset top level by the bind below.
// ====================
`timescale 1ns/1ps
`default_nettype none

module xt_chipset_props (
    input logic                      clock,
    input logic                      reset,
    input logic [xt_pkg::DMA_CH-1:0] dma_acknowledge_n,
    input logic                      address_enable,
    input logic                      processor_ready,
    input logic                      cycle_done
);

    // One DMA channel owns the bus at a time
    one_grant: assert property (@(posedge clock) disable iff (reset)
        $onehot0(~dma_acknowledge_n))
        else $error("more than one DMA acknowledge is low");

    aen_matches_ack: assert property (@(posedge clock) disable iff (reset)
        address_enable == (|(~dma_acknowledge_n)))
        else $error("address_enable does not match the DMA acknowledges");

    done_one_cycle: assert property (@(posedge clock) disable iff (reset)
        cycle_done |=> !cycle_done)
        else $error("cycle_done held for more than one cycle");

    not_ready_in_dma: assert property (@(posedge clock) disable iff (reset)
        address_enable |-> !processor_ready)
        else $error("processor_ready high during a DMA grant");

endmodule

bind xt_chipset xt_chipset_props u_xt_chipset_props (
    .clock             (clock),
    .reset             (reset),
    .dma_acknowledge_n (dma_acknowledge_n),
    .address_enable    (address_enable),
    .processor_ready   (processor_ready),
    .cycle_done        (cycle_done)
);

`default_nettype wire

// ==== tb_xt_chipset.sv ====
// ====================
// Trace-driven testbench for the chipset core.
// Runs the operations in xt_trace.txt and checks every result.
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_xt_chipset;

    localparam int WAIT_STATES = 1;
    localparam int DMA_CYCLES  = 4;
    localparam int RAM_BYTES   = 1024;

    logic                      clock;
    logic                      reset;
    logic                      cpu_start;
    xt_pkg::bus_cycle_t        cpu_cycle;
    xt_pkg::data_t             data_bus_ext;
    logic [xt_pkg::DMA_CH-1:1] dma_request;
    logic                      io_channel_ready;
    logic                      processor_ready;
    logic                      cycle_done;
    xt_pkg::data_t             read_data;
    xt_pkg::data_t             data_bus;
    logic                      timer_out;
    logic [xt_pkg::DMA_CH-1:0] dma_acknowledge_n;
    logic                      address_enable;

    byte                       op_q [$];
    int unsigned               arg_a_q [$];
    int unsigned               arg_b_q [$];
    int                        cycle_count = 0;
    int                        cycle_limit = 0;
    int                        rise_count = 0;
    int                        refresh_grants = 0;
    int                        low_run [xt_pkg::DMA_CH] = '{default: 0};
    logic                      prev_timer_out;
    logic [xt_pkg::DMA_CH-1:0] prev_ack_n;

    xt_chipset #(
        .WAIT_STATES (WAIT_STATES),
        .DMA_CYCLES  (DMA_CYCLES),
        .RAM_BYTES   (RAM_BYTES)
    ) u_xt_chipset (
        .clock             (clock),
        .reset             (reset),
        .cpu_start         (cpu_start),
        .cpu_cycle         (cpu_cycle),
        .data_bus_ext      (data_bus_ext),
        .dma_request       (dma_request),
        .io_channel_ready  (io_channel_ready),
        .processor_ready   (processor_ready),
        .cycle_done        (cycle_done),
        .read_data         (read_data),
        .data_bus          (data_bus),
        .timer_out         (timer_out),
        .dma_acknowledge_n (dma_acknowledge_n),
        .address_enable    (address_enable)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_data(input string name, input xt_pkg::data_t exp,
                                input xt_pkg::data_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_ack(input string name, input logic [xt_pkg::DMA_CH-1:0] exp,
                               input logic [xt_pkg::DMA_CH-1:0] act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    endtask

    function automatic int op_cost(input byte op, input int unsigned arg);
        case (op)
            "N":     return int'(arg);
            "T":     return 6 * int'(arg) + 8;
            "D":     return 4 * (DMA_CYCLES + 4);
            "X":     return 1;
            default: return WAIT_STATES + 12;
        endcase
    endfunction

    always @(posedge clock) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit))
            abort_run($sformatf("Timeout after %0d cycles, the trace did not complete",
                                cycle_count));
    end

    // Timer edges, refresh grants and grant lengths
    always @(negedge clock) begin
        if (!reset) begin
            if (timer_out && !prev_timer_out)
                rise_count++;
            if (!dma_acknowledge_n[0] && prev_ack_n[0])
                refresh_grants++;
            for (int ch = 0; ch < xt_pkg::DMA_CH; ch++) begin
                if (!dma_acknowledge_n[ch]) begin
                    low_run[ch]++;
                end else if (low_run[ch] != 0) begin
                    compare_count($sformatf("grant length ch%0d", ch), DMA_CYCLES, low_run[ch]);
                    low_run[ch] = 0;
                end
            end
        end
        prev_timer_out = timer_out;
        prev_ack_n     = dma_acknowledge_n;
    end

    // Drive at the falling edge, sample 10 ns later
    task automatic run_cycle(input xt_pkg::bus_cycle_t cyc, input int stall,
                             output xt_pkg::data_t rdata, output int latency);
        int   k;
        logic done;
        @(negedge clock);
        while (!processor_ready)
            @(negedge clock);
        cpu_cycle        = cyc;
        cpu_start        = 1'b1;
        io_channel_ready = (stall == 0);
        k                = 0;
        done             = 1'b0;
        @(negedge clock);
        cpu_start = 1'b0;
        while (!done) begin
            if (k >= WAIT_STATES + 1 + stall)
                io_channel_ready = 1'b1;
            #10;
            done = cycle_done;
            if (!done) begin
                @(negedge clock);
                k++;
            end
        end
        rdata   = read_data;
        latency = k + 1;
        @(negedge clock);
        #10;
        compare_count("single cycle_done", 0, int'(cycle_done));
    endtask

    task automatic cpu_access(input byte op, input int unsigned a, input int unsigned b);
        xt_pkg::bus_cycle_t cyc;
        xt_pkg::data_t      rdata;
        int                 stall;
        int                 latency;
        logic               is_ext;
        string              name;
        cyc               = '0;
        cyc.address       = xt_pkg::addr_t'(a);
        cyc.wdata         = xt_pkg::data_t'(b);
        cyc.cmd.mem_write = (op == "W");
        cyc.cmd.mem_read  = (op == "R");
        cyc.cmd.io_write  = (op == "O");
        cyc.cmd.io_read   = (op == "I");
        name              = $sformatf("%c %h", op, cyc.address);
        // External reads see a random channel stall
        is_ext = ((op == "R") && (a >= RAM_BYTES)) ||
                 ((op == "I") && (cyc.address != xt_pkg::TIMER_PORT));
        stall  = is_ext ? int'($urandom % 4) : 0;
        run_cycle(cyc, stall, rdata, latency);
        compare_count({name, " latency"}, WAIT_STATES + 2 + stall, latency);
        if ((op == "R") || (op == "I"))
            compare_data(name, xt_pkg::data_t'(b), rdata);
        else
            compare_data({name, " data_bus"}, xt_pkg::data_t'(b), data_bus);
    endtask

    task automatic dma_priority(input int unsigned mask);
        logic [xt_pkg::DMA_CH-1:0] want;
        want = xt_pkg::DMA_CH'(mask);
        @(negedge clock);
        dma_request = want[xt_pkg::DMA_CH-1:1];
        for (int ch = 1; ch < xt_pkg::DMA_CH; ch++) begin
            if (want[ch]) begin
                while ((~dma_acknowledge_n & want) == '0)
                    @(negedge clock);
                compare_ack($sformatf("priority grant ch%0d", ch),
                            ~(xt_pkg::DMA_CH'(1) << ch), dma_acknowledge_n);
                compare_count($sformatf("address_enable in grant ch%0d", ch), 1,
                              int'(address_enable));
                dma_request[ch] = 1'b0;
                want[ch]        = 1'b0;
            end
        end
    endtask

    task automatic wait_timer_level(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            #10;
            cycles++;
        end while (timer_out != level);
    endtask

    task automatic timer_check(input int unsigned divisor);
        int n;
        int rises0;
        int grants0;
        // Window opens on a falling toggle
        wait_timer_level(1'b1, n);
        wait_timer_level(1'b0, n);
        rises0  = rise_count;
        grants0 = refresh_grants;
        for (int i = 0; i < 4; i++) begin
            wait_timer_level((i % 2) == 0, n);
            compare_count("timer period", int'(divisor), n);
        end
        repeat (divisor / 2) @(negedge clock);
        #10;
        compare_count("refresh grants", rise_count - rises0, refresh_grants - grants0);
    endtask

    initial begin
        int          fd;
        int          total;
        string       line;
        int unsigned a;
        int unsigned b;
        void'($urandom(32'h55042c1d));
        reset            = 1'b1;
        cpu_start        = 1'b0;
        cpu_cycle        = '0;
        data_bus_ext     = '0;
        dma_request      = '0;
        io_channel_ready = 1'b1;
        total            = 10;
        fd = $fopen("xt_trace.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the trace file xt_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if ((line.len() > 1) && (line.getc(0) != "#")) begin
                a = 0;
                b = 0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                op_q.push_back(line.getc(0));
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
                total += op_cost(line.getc(0), a);
            end
        end
        $fclose(fd);
        cycle_limit = 50 * total;

        repeat (10) @(negedge clock);
        reset = 1'b0;
        #10;
        compare_count("processor_ready after reset", 1, int'(processor_ready));
        compare_count("cycle_done after reset", 0, int'(cycle_done));
        compare_count("address_enable after reset", 0, int'(address_enable));
        compare_count("timer_out after reset", 0, int'(timer_out));
        compare_ack("acknowledge after reset", '1, dma_acknowledge_n);

        for (int i = 0; i < op_q.size(); i++) begin
            repeat ($urandom % 3) @(negedge clock);
            case (op_q[i])
                "X": begin
                    @(negedge clock);
                    data_bus_ext = xt_pkg::data_t'(arg_a_q[i]);
                end
                "N":                cpu_idle(arg_a_q[i]);
                "D":                dma_priority(arg_a_q[i]);
                "T":                timer_check(arg_a_q[i]);
                "W", "R", "O", "I": cpu_access(op_q[i], arg_a_q[i], arg_b_q[i]);
                default:            abort_run($sformatf("Unknown trace operation %c", op_q[i]));
            endcase
        end
        $display("Simulation completed successfully");
        $finish;
    end

    task automatic cpu_idle(input int unsigned cycles);
        repeat (cycles) @(negedge clock);
    endtask

endmodule

`default_nettype wire

// ==== xt_trace.txt ====
# op arg1 arg2: W addr data = memory write, R addr data = memory read expecting data
# O port data = I/O write, I port data = I/O read, X data = external bus, D mask = DMA, N = idle, T div = timer
I 00041 00
W 00000 a5
W 00001 3c
W 003ff 7e
W 00200 11
W 00400 ee
R 00000 a5
R 00001 3c
R 003ff 7e
R 00200 11
X c3
R 00400 c3
R 80000 c3
X 96
I 00060 96
I 00042 96
O 00041 10
I 00041 10
T 10
D a
N 20
W 00010 5f
R 00010 5f
O 00041 14
I 00041 14
T 14
D c
R 00010 5f
O 00041 00
I 00041 00

// ==== list.f ====
xt_pkg.sv
refresh_request.sv
dma_arbiter.sv
ready_gen.sv
interval_timer.sv
bus_decode.sv
ram_block.sv
xt_chipset.sv
xt_chipset_props.sv
tb_xt_chipset.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the chipset testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_xt_chipset

# The log decides pass or fail
./obj_dir/Vtb_xt_chipset > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "RESULT: FAIL, the run ended without a result"
    exit 1
fi
echo "RESULT: PASS"
